/* Makefile */
# Verilator flow for the ARM core

TOP       ?= armCoreTb
VERILATOR ?= verilator
FLAGS     ?= --assert
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
PASS_MSG  := All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* all.f */
logic/armPkg.sv
logic/alu.sv
logic/regFile.sv
logic/instrDecoder.sv
logic/condUnit.sv
logic/datapath.sv
logic/armCore.sv
sim/armCore_chk.sv
sim/armCoreTb.sv

/* logic/alu.sv */
// Four-operation ALU
`default_nettype none
`timescale 1ns/100ps

module alu (
  input  wire armPkg::wordT  a,
  input  wire armPkg::wordT  b,
  input  wire armPkg::aluOpT aluOp,
  output armPkg::wordT       result,
  output armPkg::flagsT      flags
);

  logic                      isSub, isArith;
  armPkg::wordT              bInv;
  logic [armPkg::dataWidth:0] sum;  // Extra bit holds the carry out

  assign isSub   = (aluOp == armPkg::aluSub);
  assign isArith = (aluOp == armPkg::aluAdd) | isSub;
  assign bInv    = isSub ? ~b : b;
  assign sum     = {1'b0, a} + {1'b0, bInv} + {{armPkg::dataWidth{1'b0}}, isSub};

  always_comb
  begin
    case (aluOp)
      armPkg::aluAdd,
      armPkg::aluSub: result = sum[armPkg::dataWidth-1:0];
      armPkg::aluAnd: result = a & b;
      armPkg::aluOrr: result = a | b;
      default:        result = '0;
    endcase
  end

  assign flags.neg      = result[armPkg::dataWidth-1];
  assign flags.zero     = (result == '0);
  assign flags.carry    = isArith & sum[armPkg::dataWidth];  // No borrow on SUB
  // Operands of like sign, result of the other
  assign flags.overflow = isArith
                        & ~(a[armPkg::dataWidth-1] ^ b[armPkg::dataWidth-1] ^ isSub)
                        & (a[armPkg::dataWidth-1] ^ sum[armPkg::dataWidth-1]);

endmodule

`default_nettype wire

/* logic/armCore.sv */
// Single-cycle ARM core top
`default_nettype none
`timescale 1ns/100ps

module armCore (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire armPkg::wordT instr,     // From instruction memory
  input  wire armPkg::wordT readData,  // Load data
  output armPkg::wordT     pc,
  output logic             memWrite,   // Store strobe, gated by condition
  output armPkg::wordT     aluResult,  // Also the data address
  output armPkg::wordT     writeData   // Store data
);

  logic [1:0]     flagWrite;
  logic           pcSelect, regWrite, memWriteDec;  // Ungated decoder levels
  logic           memToReg, aluSrc, regSrc;
  armPkg::immSrcT immSrc;
  armPkg::aluOpT  aluOp;
  logic           pcSrc, regWriteEn;                // Gated by condition
  armPkg::flagsT  aluFlags;

  // Main and ALU decode from instr[27:12]
  instrDecoder decoder0 (
    .op(armPkg::opT'(instr[27:26])), .funct(instr[25:20]), .rd(instr[15:12]),
    .flagWrite(flagWrite), .pcSelect(pcSelect), .regWrite(regWrite),
    .memWrite(memWriteDec), .memToReg(memToReg), .aluSrc(aluSrc),
    .immSrc(immSrc), .regSrc(regSrc), .aluOp(aluOp)
  );

  condUnit cond0 (
    .clk(clk), .reset(reset), .cond(armPkg::condT'(instr[31:28])),
    .aluFlags(aluFlags), .flagWrite(flagWrite), .pcSelect(pcSelect),
    .regWrite(regWrite), .memWrite(memWriteDec),
    .pcSrc(pcSrc), .regWriteEn(regWriteEn), .memWriteEn(memWrite)
  );

  datapath datapath0 (
    .clk(clk), .reset(reset), .instr(instr), .readData(readData),
    .regSrc(regSrc), .regWriteEn(regWriteEn), .immSrc(immSrc), .aluSrc(aluSrc),
    .aluOp(aluOp), .memToReg(memToReg), .pcSrc(pcSrc),
    .pc(pc), .aluResult(aluResult), .writeData(writeData), .aluFlags(aluFlags)
  );

endmodule

`default_nettype wire

/* logic/armPkg.sv */
// ARM core shared definitions
`default_nettype none

package armPkg;

  localparam int dataWidth    = 32;  // Data and address width
  localparam int regAddrWidth = 4;   // Register index width

  typedef logic [dataWidth-1:0]    wordT;
  typedef logic [regAddrWidth-1:0] regAddrT;

  localparam regAddrT pcRegIdx    = regAddrT'(15);  // R15, the PC
  localparam wordT    pcStep      = wordT'(4);      // One instruction word
  localparam wordT    pcReadAhead = wordT'(8);      // R15 reads two words ahead

  // Instruction class, instr[27:26]
  typedef enum logic [1:0] {
    opDataProc = 2'b00,
    opMemory   = 2'b01,
    opBranch   = 2'b10
  } opT;

  typedef enum logic [1:0] {
    aluAdd = 2'b00,
    aluSub = 2'b01,
    aluAnd = 2'b10,
    aluOrr = 2'b11
  } aluOpT;

  // ARM cond field; 1111 is not used
  typedef enum logic [3:0] {
    condEq = 4'b0000, condNe = 4'b0001, condCs = 4'b0010, condCc = 4'b0011,
    condMi = 4'b0100, condPl = 4'b0101, condVs = 4'b0110, condVc = 4'b0111,
    condHi = 4'b1000, condLs = 4'b1001, condGe = 4'b1010, condLt = 4'b1011,
    condGt = 4'b1100, condLe = 4'b1101, condAl = 4'b1110
  } condT;

  typedef enum logic [1:0] {
    immByte     = 2'b00,  // DP imm8, zero-extended
    immOffset12 = 2'b01,  // LDR/STR offset, zero-extended
    immBranch   = 2'b10   // imm24, sign-extended, word offset
  } immSrcT;

  typedef struct packed {
    logic neg;
    logic zero;
    logic carry;
    logic overflow;
  } flagsT;

endpackage

`default_nettype wire

/* logic/condUnit.sv */
// Condition check and write gating
`default_nettype none
`timescale 1ns/100ps

module condUnit (
  input  wire logic          clk,
  input  wire logic          reset,
  input  wire armPkg::condT  cond,       // instr[31:28]
  input  wire armPkg::flagsT aluFlags,   // From the ALU this cycle
  input  wire logic [1:0]    flagWrite,
  input  wire logic          pcSelect,
  input  wire logic          regWrite,
  input  wire logic          memWrite,
  output logic               pcSrc,
  output logic               regWriteEn,
  output logic               memWriteEn
);

  armPkg::flagsT flags;        // Stored NZCV
  logic [1:0]    flagWriteEn;
  logic          condEx;       // Condition passes
  logic          ge;

  // NZ and CV halves load separately
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      flags <= '0;
    end
    else
    begin
      if (flagWriteEn[1])
        {flags.neg, flags.zero} <= {aluFlags.neg, aluFlags.zero};
      if (flagWriteEn[0])
        {flags.carry, flags.overflow} <= {aluFlags.carry, aluFlags.overflow};
    end
  end

  assign ge = (flags.neg == flags.overflow);  // Signed greater or equal

  always_comb
  begin
    case (cond)
      armPkg::condEq: condEx = flags.zero;
      armPkg::condNe: condEx = ~flags.zero;
      armPkg::condCs: condEx = flags.carry;
      armPkg::condCc: condEx = ~flags.carry;
      armPkg::condMi: condEx = flags.neg;
      armPkg::condPl: condEx = ~flags.neg;
      armPkg::condVs: condEx = flags.overflow;
      armPkg::condVc: condEx = ~flags.overflow;
      armPkg::condHi: condEx = flags.carry & ~flags.zero;    // Unsigned higher
      armPkg::condLs: condEx = ~flags.carry | flags.zero;
      armPkg::condGe: condEx = ge;
      armPkg::condLt: condEx = ~ge;
      armPkg::condGt: condEx = ~flags.zero & ge;
      armPkg::condLe: condEx = flags.zero | ~ge;
      armPkg::condAl: condEx = 1'b1;
      default:        condEx = 1'b0;                         // 1111 never executes
    endcase
  end

  // Every architectural write waits on the condition
  assign flagWriteEn = flagWrite & {2{condEx}};
  assign regWriteEn  = regWrite & condEx;
  assign memWriteEn  = memWrite & condEx;
  assign pcSrc       = pcSelect & condEx;

endmodule

`default_nettype wire

/* logic/datapath.sv */
// Core datapath
`default_nettype none
`timescale 1ns/100ps

module datapath (
  input  wire logic           clk,
  input  wire logic           reset,
  input  wire armPkg::wordT   instr,
  input  wire armPkg::wordT   readData,
  input  wire logic           regSrc,
  input  wire logic           regWriteEn,
  input  wire armPkg::immSrcT immSrc,
  input  wire logic           aluSrc,
  input  wire armPkg::aluOpT  aluOp,
  input  wire logic           memToReg,
  input  wire logic           pcSrc,
  output armPkg::wordT        pc,
  output armPkg::wordT        aluResult,
  output armPkg::wordT        writeData,
  output armPkg::flagsT       aluFlags
);

  armPkg::wordT    pcNext, pcPlus4, pcPlus8;
  armPkg::wordT    extImm, srcA, srcB, result;
  armPkg::regAddrT readAddr1, readAddr2;

  // PC register
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= '0;
    else
      pc <= pcNext;
  end

  assign pcPlus4 = pc + armPkg::pcStep;
  assign pcPlus8 = pc + armPkg::pcReadAhead;  // Value of R15 on read
  assign pcNext  = pcSrc ? result : pcPlus4;  // Branch or write to R15

  // Branch target is relative to R15, imm24 overlaps Rn
  assign readAddr1 = (immSrc == armPkg::immBranch) ? armPkg::pcRegIdx : instr[19:16];
  assign readAddr2 = regSrc ? instr[15:12] : instr[3:0];  // Rd for STR, else Rm

  regFile regFile0 (
    .clk(clk),
    .writeEn(regWriteEn),
    .readAddr1(readAddr1),
    .readAddr2(readAddr2),
    .writeAddr(instr[15:12]),
    .writeData(result),
    .pcPlus8(pcPlus8),
    .readData1(srcA),
    .readData2(writeData)
  );

  // Immediate extension
  always_comb
  begin
    case (immSrc)
      armPkg::immByte:     extImm = {{(armPkg::dataWidth - 8){1'b0}}, instr[7:0]};
      armPkg::immOffset12: extImm = {{(armPkg::dataWidth - 12){1'b0}}, instr[11:0]};
      armPkg::immBranch:
        extImm = {{(armPkg::dataWidth - 26){instr[23]}}, instr[23:0], 2'b00};
      default:             extImm = '0;
    endcase
  end

  assign srcB = aluSrc ? extImm : writeData;

  alu alu0 (
    .a(srcA),
    .b(srcB),
    .aluOp(aluOp),
    .result(aluResult),
    .flags(aluFlags)
  );

  assign result = memToReg ? readData : aluResult;  // LDR data or ALU

endmodule

`default_nettype wire

/* logic/instrDecoder.sv */
// Main and ALU decoder
`default_nettype none
`timescale 1ns/100ps

module instrDecoder (
  input  wire armPkg::opT    op,         // instr[27:26]
  input  wire logic [5:0]    funct,      // instr[25:20], I..S/L
  input  wire armPkg::regAddrT rd,       // instr[15:12]
  output logic [1:0]         flagWrite,  // [1] NZ, [0] CV
  output logic               pcSelect,
  output logic               regWrite,
  output logic               memWrite,
  output logic               memToReg,
  output logic               aluSrc,     // 1 selects the immediate
  output armPkg::immSrcT     immSrc,
  output logic               regSrc,     // 1 reads Rd on port 2
  output armPkg::aluOpT      aluOp
);

  logic branch;
  logic isDataProc;

  // Main decoder
  always_comb
  begin
    regSrc     = 1'b0;
    immSrc     = armPkg::immByte;
    aluSrc     = 1'b0;
    memToReg   = 1'b0;
    regWrite   = 1'b0;
    memWrite   = 1'b0;
    branch     = 1'b0;
    isDataProc = 1'b0;
    case (op)
      armPkg::opDataProc:
      begin
        aluSrc     = funct[5];  // I bit
        regWrite   = 1'b1;
        isDataProc = 1'b1;
      end
      armPkg::opMemory:
      begin
        immSrc   = armPkg::immOffset12;
        aluSrc   = 1'b1;
        memToReg = funct[0];    // L bit, LDR
        regWrite = funct[0];
        memWrite = ~funct[0];   // STR
        regSrc   = ~funct[0];   // Store data comes from Rd
      end
      armPkg::opBranch:
      begin
        immSrc = armPkg::immBranch;
        aluSrc = 1'b1;
        branch = 1'b1;
      end
      default: ;                // Unused class, no writes
    endcase
  end

  // ALU decoder
  always_comb
  begin
    aluOp     = armPkg::aluAdd;  // Address and branch target add
    flagWrite = 2'b00;
    if (isDataProc)
    begin
      case (funct[4:1])
        4'b0100: aluOp = armPkg::aluAdd;
        4'b0010: aluOp = armPkg::aluSub;
        4'b0000: aluOp = armPkg::aluAnd;
        4'b1100: aluOp = armPkg::aluOrr;
        default: aluOp = armPkg::aluAdd;
      endcase
      flagWrite[1] = funct[0];  // S bit
      flagWrite[0] = funct[0] & (aluOp == armPkg::aluAdd || aluOp == armPkg::aluSub);
    end
  end

  // Write to R15 is a jump
  assign pcSelect = branch | (regWrite & (rd == armPkg::pcRegIdx));

endmodule

`default_nettype wire

/* logic/regFile.sv */
// Register file with R15 as PC+8
`default_nettype none
`timescale 1ns/100ps

module regFile (
  input  wire logic            clk,
  input  wire logic            writeEn,
  input  wire armPkg::regAddrT readAddr1,
  input  wire armPkg::regAddrT readAddr2,
  input  wire armPkg::regAddrT writeAddr,
  input  wire armPkg::wordT    writeData,
  input  wire armPkg::wordT    pcPlus8,    // Returned for R15
  output armPkg::wordT         readData1,
  output armPkg::wordT         readData2
);

  armPkg::wordT regs [0:armPkg::pcRegIdx-1];  // R0..R14

  // R15 writes go to the PC, not here
  always_ff @(posedge clk)
  begin
    if (writeEn && writeAddr != armPkg::pcRegIdx)
      regs[writeAddr] <= writeData;
  end

  assign readData1 = (readAddr1 == armPkg::pcRegIdx) ? pcPlus8 : regs[readAddr1];
  assign readData2 = (readAddr2 == armPkg::pcRegIdx) ? pcPlus8 : regs[readAddr2];

endmodule

`default_nettype wire

/* sim/armCoreTb.sv */
// ARM core testbench
`default_nettype none
`timescale 1ns/100ps

module armCoreTb;

  localparam int halfPeriod    = 50;  // 100 ns clock
  localparam int settleTime    = 40;  // Check 10 ns before the rising edge
  localparam int resetCycles   = 10;
  localparam int randPairs     = 20;  // ADD then STR, two cycles each
  localparam int timeoutMargin = 20;

  // ARM data-processing cmd field
  localparam logic [3:0] cmdAnd = 4'b0000;
  localparam logic [3:0] cmdSub = 4'b0010;
  localparam logic [3:0] cmdAdd = 4'b0100;
  localparam logic [3:0] cmdOrr = 4'b1100;

  typedef struct {
    armPkg::wordT instr;
    armPkg::wordT readData;   // Load data for this step
    armPkg::wordT pc;
    logic         memWrite;
    armPkg::wordT aluResult;
    logic         checkWd;    // writeData only matters for stores
    armPkg::wordT writeData;
  } stepT;

  logic         clk;
  logic         reset;
  armPkg::wordT instr;
  armPkg::wordT readData;
  armPkg::wordT pc;
  logic         memWrite;
  armPkg::wordT aluResult;
  armPkg::wordT writeData;

  stepT stimRows [$];
  int   stepIndex  = 0;
  int   cycleCount = 0;

  armCore dut0 (
    .clk(clk), .reset(reset), .instr(instr), .readData(readData),
    .pc(pc), .memWrite(memWrite), .aluResult(aluResult), .writeData(writeData)
  );

  always #halfPeriod clk = ~clk;

  // Instruction encoders
  function automatic armPkg::wordT dpImm(armPkg::condT c, logic [3:0] cmd, int s, int rn,
                                         int rd, int imm);
    return {c, 2'b00, 1'b1, cmd, s[0], rn[3:0], rd[3:0], 4'h0, imm[7:0]};
  endfunction

  function automatic armPkg::wordT dpReg(armPkg::condT c, logic [3:0] cmd, int s, int rn,
                                         int rd, int rm);
    return {c, 2'b00, 1'b0, cmd, s[0], rn[3:0], rd[3:0], 8'h00, rm[3:0]};
  endfunction

  function automatic armPkg::wordT memInstr(armPkg::condT c, int load, int rn, int rd, int off);
    return {c, 2'b01, 5'b01100, load[0], rn[3:0], rd[3:0], off[11:0]};  // P=1, U=1
  endfunction

  function automatic armPkg::wordT branchInstr(armPkg::condT c, int off);
    return {c, 4'b1010, off[23:0]};
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic failRun();
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkWord(input string name, input armPkg::wordT got,
                           input armPkg::wordT expected);
    if (got !== expected)
    begin
      $display("MISMATCH %s at step %0d: got 0x%08h, expected 0x%08h",
               name, stepIndex, got, expected);
      failRun();
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic expected);
    if (got !== expected)
    begin
      $display("MISMATCH %s at step %0d: got 0x%h, expected 0x%h",
               name, stepIndex, got, expected);
      failRun();
    end
  endtask

  task automatic addRow(input armPkg::wordT ins, input armPkg::wordT rdata,
                        input armPkg::wordT expPc, input int expMw,
                        input armPkg::wordT expAlu, input int chkWd,
                        input armPkg::wordT expWd);
    stepT row;
    row.instr     = ins;
    row.readData  = rdata;
    row.pc        = expPc;
    row.memWrite  = (expMw != 0);
    row.aluResult = expAlu;
    row.checkWd   = (chkWd != 0);
    row.writeData = expWd;
    stimRows.push_back(row);
  endtask

  // Drive on the falling edge, check before the rising edge
  task automatic runStep(input stepT row);
    instr    = row.instr;
    readData = row.readData;
    #settleTime;
    checkWord("pc", pc, row.pc);
    checkBit("memWrite", memWrite, row.memWrite);
    checkWord("aluResult", aluResult, row.aluResult);
    if (row.checkWd)
      checkWord("writeData", writeData, row.writeData);
    @(negedge clk);
  endtask

  task automatic buildTable();
    // R15 reads pc+8, then immediate and register ALU ops
    addRow(dpImm(armPkg::condAl, cmdAdd, 0, 15, 1, 'h00), 0, 'h00, 0, 'h08, 0, 0);
    addRow(dpImm(armPkg::condAl, cmdSub, 0, 1, 2, 'h03), 0, 'h04, 0, 'h05, 0, 0);
    addRow(dpImm(armPkg::condAl, cmdAnd, 0, 1, 3, 'h0C), 0, 'h08, 0, 'h08, 0, 0);
    addRow(dpImm(armPkg::condAl, cmdOrr, 0, 2, 4, 'h30), 0, 'h0C, 0, 'h35, 0, 0);
    addRow(dpReg(armPkg::condAl, cmdAdd, 0, 4, 5, 2), 0, 'h10, 0, 'h3A, 0, 0);
    addRow(dpReg(armPkg::condAl, cmdSub, 0, 5, 6, 1), 0, 'h14, 0, 'h32, 0, 0);
    addRow(dpReg(armPkg::condAl, cmdAnd, 0, 4, 7, 5), 0, 'h18, 0, 'h30, 0, 0);
    addRow(dpReg(armPkg::condAl, cmdOrr, 0, 2, 8, 1), 0, 'h1C, 0, 'h0D, 0, 0);
    // Stores show register contents, LDR data lands in R9
    addRow(memInstr(armPkg::condAl, 0, 1, 6, 'h010), 0, 'h20, 1, 'h18, 1, 'h32);
    addRow(memInstr(armPkg::condAl, 0, 8, 7, 'h004), 0, 'h24, 1, 'h11, 1, 'h30);
    addRow(memInstr(armPkg::condAl, 1, 2, 9, 'h020), 'hCAFE1234, 'h28, 0, 'h25, 0, 0);
    addRow(memInstr(armPkg::condAl, 0, 1, 9, 'h000), 0, 'h2C, 1, 'h08, 1, 'hCAFE1234);
    // Equal operands, Z=1 C=1
    addRow(dpReg(armPkg::condAl, cmdSub, 1, 2, 10, 2), 0, 'h30, 0, 'h00, 0, 0);
    addRow(memInstr(armPkg::condEq, 0, 1, 5, 'h000), 0, 'h34, 1, 'h08, 1, 'h3A);
    addRow(memInstr(armPkg::condNe, 0, 1, 5, 'h000), 0, 'h38, 0, 'h08, 0, 0);
    addRow(memInstr(armPkg::condCs, 0, 1, 5, 'h000), 0, 'h3C, 1, 'h08, 1, 'h3A);
    addRow(memInstr(armPkg::condLs, 0, 1, 5, 'h000), 0, 'h40, 1, 'h08, 1, 'h3A);
    addRow(memInstr(armPkg::condGt, 0, 1, 5, 'h000), 0, 'h44, 0, 'h08, 0, 0);
    // 5 - 8 gives N=1 C=0
    addRow(dpReg(armPkg::condAl, cmdSub, 1, 2, 10, 1), 0, 'h48, 0, 'hFFFFFFFD, 0, 0);
    addRow(memInstr(armPkg::condLt, 0, 1, 10, 'h000), 0, 'h4C, 1, 'h08, 1, 'hFFFFFFFD);
    addRow(memInstr(armPkg::condGe, 0, 1, 10, 'h000), 0, 'h50, 0, 'h08, 0, 0);
    addRow(memInstr(armPkg::condHi, 0, 1, 10, 'h000), 0, 'h54, 0, 'h08, 0, 0);
    addRow(dpImm(armPkg::condNe, cmdAdd, 0, 1, 11, 'h02), 0, 'h58, 0, 'h0A, 0, 0);
    addRow(dpImm(armPkg::condEq, cmdAdd, 0, 1, 11, 'h01), 0, 'h5C, 0, 'h09, 0, 0);
    // AND without S, N stays set
    addRow(dpImm(armPkg::condAl, cmdAnd, 0, 1, 12, 'h00), 0, 'h60, 0, 'h00, 0, 0);
    addRow(memInstr(armPkg::condPl, 0, 1, 11, 'h000), 0, 'h64, 0, 'h08, 0, 0);
    addRow(memInstr(armPkg::condMi, 0, 1, 11, 'h000), 0, 'h68, 1, 'h08, 1, 'h0A);
    // Signed overflow on ADDS
    addRow(memInstr(armPkg::condAl, 1, 1, 13, 'h000), 'h7FFFFFF0, 'h6C, 0, 'h08, 0, 0);
    addRow(dpImm(armPkg::condAl, cmdAdd, 1, 13, 14, 'h20), 0, 'h70, 0, 'h80000010, 0, 0);
    addRow(memInstr(armPkg::condVs, 0, 1, 14, 'h000), 0, 'h74, 1, 'h08, 1, 'h80000010);
    addRow(memInstr(armPkg::condVc, 0, 1, 14, 'h000), 0, 'h78, 0, 'h08, 0, 0);
    // Forward, failing and backward branches
    addRow(branchInstr(armPkg::condAl, 1), 0, 'h7C, 0, 'h88, 0, 0);
    addRow(branchInstr(armPkg::condEq, 5), 0, 'h88, 0, 'hA4, 0, 0);
    addRow(branchInstr(armPkg::condAl, -2), 0, 'h8C, 0, 'h8C, 0, 0);
    addRow(dpImm(armPkg::condAl, cmdAdd, 0, 1, 15, 'h78), 0, 'h8C, 0, 'h80, 0, 0);  // Jump
    addRow(dpImm(armPkg::condAl, cmdAdd, 0, 15, 3, 'h00), 0, 'h80, 0, 'h88, 0, 0);
  endtask

  always @(posedge clk)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount > resetCycles + stimRows.size() + timeoutMargin)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycleCount - 1);
      failRun();
    end
  end

  initial
  begin
    armPkg::wordT model [0:14];  // Register contents after the table
    logic [31:0]  rngState;
    armPkg::wordT lastPc;
    int           rd, rn, rs, imm, off;
    clk      = 1'b0;
    reset    = 1'b1;
    instr    = '0;
    readData = '0;
    rngState = 32'd11;
    buildTable();
    model = '{0, 'h8, 'h5, 'h88, 'h35, 'h3A, 'h32, 'h30, 'hD, 'hCAFE1234,
              'hFFFFFFFD, 'hA, 'h0, 'h7FFFFFF0, 'h80000010};
    lastPc = stimRows[$].pc + 4;
    // Random ADD immediate, then store of its result
    for (int i = 0; i < randPairs; i++)
    begin
      rngState = xorshift(rngState);
      rd  = 1 + rngState % 14;         // R1..R14
      rn  = 1 + (rngState >> 8) % 14;
      imm = (rngState >> 16) & 'hFF;
      addRow(dpImm(armPkg::condAl, cmdAdd, 0, rn, rd, imm), 0, lastPc, 0,
             model[rn[3:0]] + imm, 0, 0);
      model[rd[3:0]] = model[rn[3:0]] + imm;
      rngState = xorshift(rngState);
      rs  = 1 + rngState % 14;
      off = (rngState >> 8) & 'hFFF;
      addRow(memInstr(armPkg::condAl, 0, rs, rd, off), 0, lastPc + 4, 1,
             model[rs[3:0]] + off, 1, model[rd[3:0]]);
      lastPc = lastPc + 8;
    end
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < stimRows.size(); i++)
    begin
      stepIndex = i;
      runStep(stimRows[i]);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/armCore_chk.sv */
// ARM core bound assertions
`default_nettype none
`timescale 1ns/100ps

module armCoreChk (
  input wire logic         clk,
  input wire logic         reset,
  input wire armPkg::wordT pc,
  input wire armPkg::wordT instr,
  input wire logic         memWrite
);

  // Branch targets and R15 writes stay on word boundaries here
  pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc 0x%08h is not word-aligned", pc);

  pcKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(pc))
    else $error("pc holds an unknown value out of reset");

  // Only LDR/STR class may strobe memory
  memWriteClass: assert property (@(posedge clk) disable iff (reset)
      memWrite |-> (armPkg::opT'(instr[27:26]) == armPkg::opMemory))
    else $error("memWrite high for instruction 0x%08h", instr);

endmodule

bind armCore armCoreChk chk0 (
  .clk(clk),
  .reset(reset),
  .pc(pc),
  .instr(instr),
  .memWrite(memWrite)
);

`default_nettype wire
